// ==== src.f ====
logic/pcie_app_pkg.sv
logic/stream_fifo.sv
logic/write_commit_gen.sv
logic/rxreq_arbiter.sv
logic/tag_mode_shadow.sv
logic/pcie_app_bridge.sv
bench/tb_pcie_app_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bridge testbench with Verilator, log in sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Mdir obj_dir -o sim_tb \
   --top-module tb_pcie_app_bridge -f src.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
   exit 1
fi
exit 0

// ==== bench/tb_pcie_app_bridge.sv ====
// ------------------------------
// Stimulus changes on the falling edge, monitors sample on the rising edge
// RXREQ packets never open with OP_CPL_NODATA, so the opcode names the source
// ------------------------------

`timescale 1ns/10ps

module tb_pcie_app_bridge;

   localparam int N_PASS  = 8;
   localparam int N_CMT   = 10;
   localparam int N_MERGE = 8;
   localparam int N_BP    = 12;
   localparam int MAX_LEN = 4;
   localparam int MAX_BEATS = (N_PASS + N_CMT + 2 * N_MERGE + 2 * N_BP) * (MAX_LEN + 1);
   localparam int WATCHDOG_CYCLES = MAX_BEATS * 50 + 200;
   localparam int DRAIN_CYCLES    = 2000;

   logic                                  fim_clk;
   logic                                  arst_n;
   logic                                  tx_in_tvalid;
   logic                                  tx_in_tready;
   logic                                  tx_in_tlast;
   pcie_app_pkg::t_tdata                  tx_in_tdata;
   logic                                  tx_out_tvalid;
   logic                                  tx_out_tready;
   logic                                  tx_out_tlast;
   pcie_app_pkg::t_tdata                  tx_out_tdata;
   logic                                  rxreq_in_tvalid;
   logic                                  rxreq_in_tready;
   logic                                  rxreq_in_tlast;
   pcie_app_pkg::t_tdata                  rxreq_in_tdata;
   logic                                  rxreq_out_tvalid;
   logic                                  rxreq_out_tready;
   logic                                  rxreq_out_tlast;
   pcie_app_pkg::t_tdata                  rxreq_out_tdata;
   logic                                  ctrlshadow_tvalid;
   logic [pcie_app_pkg::CTRLSHADOW_W-1:0] ctrlshadow_tdata;
   pcie_app_pkg::t_tag_mode               tag_mode;

   // Reference queues
   pcie_app_pkg::t_tdata tx_exp_data[$];
   logic                 tx_exp_last[$];
   pcie_app_pkg::t_tdata rx_exp_data[$];
   logic                 rx_exp_last[$];
   pcie_app_pkg::t_tdata cpl_exp[$];

   int   beat_errors  = 0;
   int   mode_errors  = 0;
   int   flag_errors  = 0;
   int   other_errors = 0;
   logic rand_ready   = 1'b0;   // Random back-pressure on both outputs
   logic rx_in_pkt    = 1'b0;
   logic rx_src       = 1'b0;   // 1 while a commit is on rxreq_out

   pcie_app_bridge #(
      .RXREQ_DEPTH  (4),
      .COMMIT_DEPTH (4)
   ) dut (
      .fim_clk           (fim_clk),
      .arst_n            (arst_n),
      .tx_in_tvalid      (tx_in_tvalid),
      .tx_in_tready      (tx_in_tready),
      .tx_in_tlast       (tx_in_tlast),
      .tx_in_tdata       (tx_in_tdata),
      .tx_out_tvalid     (tx_out_tvalid),
      .tx_out_tready     (tx_out_tready),
      .tx_out_tlast      (tx_out_tlast),
      .tx_out_tdata      (tx_out_tdata),
      .rxreq_in_tvalid   (rxreq_in_tvalid),
      .rxreq_in_tready   (rxreq_in_tready),
      .rxreq_in_tlast    (rxreq_in_tlast),
      .rxreq_in_tdata    (rxreq_in_tdata),
      .rxreq_out_tvalid  (rxreq_out_tvalid),
      .rxreq_out_tready  (rxreq_out_tready),
      .rxreq_out_tlast   (rxreq_out_tlast),
      .rxreq_out_tdata   (rxreq_out_tdata),
      .ctrlshadow_tvalid (ctrlshadow_tvalid),
      .ctrlshadow_tdata  (ctrlshadow_tdata),
      .tag_mode          (tag_mode)
   );

   initial
   begin
      fim_clk = 1'b0;
      forever #10 fim_clk = ~fim_clk;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge fim_clk);
      $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_beat(input string what, input pcie_app_pkg::t_tdata got_d,
                             input logic got_l, input pcie_app_pkg::t_tdata exp_d,
                             input logic exp_l);
      if (got_d !== exp_d || got_l !== exp_l)
      begin
         $display("error at %0t: %s beat is %h/%b, expected %h/%b",
                  $time, what, got_d, got_l, exp_d, exp_l);
         beat_errors++;
      end
   endtask

   task automatic check_tag_mode(input string what, input pcie_app_pkg::t_tag_mode got,
                                 input pcie_app_pkg::t_tag_mode exp);
      if (got !== exp)
      begin
         $display("error at %0t: tag_mode %s is %0d, expected %0d", $time, what, got, exp);
         mode_errors++;
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
         flag_errors++;
      end
   endtask

   // ------------------------------
   // Monitors and ready patterns
   // ------------------------------
   always @(posedge fim_clk)
   begin
      if (arst_n && tx_out_tvalid && tx_out_tready)
      begin
         if (tx_exp_data.size() == 0)
         begin
            $display("Unexpected TX beat %h at %0t", tx_out_tdata, $time);
            other_errors++;
         end
         else
            check_beat("TX", tx_out_tdata, tx_out_tlast, tx_exp_data.pop_front(),
                       tx_exp_last.pop_front());
      end
   end

   always @(posedge fim_clk)
   begin
      if (arst_n && rxreq_out_tvalid && rxreq_out_tready)
      begin
         if (!rx_in_pkt)          // First beat names the source
            rx_src = (rxreq_out_tdata[pcie_app_pkg::OPCODE_LSB +: pcie_app_pkg::OPCODE_W]
                      == pcie_app_pkg::OP_CPL_NODATA);
         if (rx_src && cpl_exp.size() != 0)
            check_beat("commit", rxreq_out_tdata, rxreq_out_tlast, cpl_exp.pop_front(), 1'b1);
         else if (!rx_src && rx_exp_data.size() != 0)
            check_beat("RXREQ", rxreq_out_tdata, rxreq_out_tlast, rx_exp_data.pop_front(),
                       rx_exp_last.pop_front());
         else
         begin
            $display("Unexpected beat %h on rxreq_out at %0t", rxreq_out_tdata, $time);
            other_errors++;
         end
         rx_in_pkt = !rxreq_out_tlast;
      end
   end

   always @(negedge fim_clk)
   begin
      if (rand_ready)
      begin
         tx_out_tready    = ($urandom % 4) != 0;
         rxreq_out_tready = ($urandom % 3) == 0;
      end
      else
      begin
         tx_out_tready    = 1'b1;
         rxreq_out_tready = 1'b1;
      end
   end

   // ------------------------------
   // Drivers
   // ------------------------------
   function automatic pcie_app_pkg::t_opcode pick_opcode();
      case ($urandom % 3)
         0:       return pcie_app_pkg::OP_MRD;
         1:       return pcie_app_pkg::OP_MSG;
         default: return pcie_app_pkg::OP_MWR;
      endcase
   endfunction

   function automatic pcie_app_pkg::t_tdata first_beat(input pcie_app_pkg::t_opcode op,
                                                       input logic commit,
                                                       input pcie_app_pkg::t_tag tag);
      pcie_app_pkg::t_tdata d;
      d = {$urandom, $urandom};
      d[pcie_app_pkg::OPCODE_LSB +: pcie_app_pkg::OPCODE_W] = op;
      d[pcie_app_pkg::COMMIT_REQ_BIT]                       = commit;
      d[pcie_app_pkg::TAG_LSB +: pcie_app_pkg::TAG_W]       = tag;
      return d;
   endfunction

   task automatic send_tx_packet(input pcie_app_pkg::t_opcode op, input logic commit,
                                 input int len);
      pcie_app_pkg::t_tdata d;
      pcie_app_pkg::t_tdata cpl;
      pcie_app_pkg::t_tag   tag;
      tag = pcie_app_pkg::t_tag'($urandom);
      if (op == pcie_app_pkg::OP_MWR && commit)
      begin
         cpl = '0;                // Completion carries opcode and tag only
         cpl[pcie_app_pkg::OPCODE_LSB +: pcie_app_pkg::OPCODE_W] = pcie_app_pkg::OP_CPL_NODATA;
         cpl[pcie_app_pkg::TAG_LSB +: pcie_app_pkg::TAG_W]       = tag;
         cpl_exp.push_back(cpl);
      end
      for (int i = 0; i < len; i++)
      begin
         d = (i == 0) ? first_beat(op, commit, tag) : {$urandom, $urandom};
         tx_exp_data.push_back(d);
         tx_exp_last.push_back(i == len - 1);
         @(negedge fim_clk);
         tx_in_tvalid = 1'b1;
         tx_in_tdata  = d;
         tx_in_tlast  = (i == len - 1);
         @(posedge fim_clk);
         while (!tx_in_tready) @(posedge fim_clk);
      end
      @(negedge fim_clk);
      tx_in_tvalid = 1'b0;
   endtask

   task automatic send_rx_packet(input int len);
      pcie_app_pkg::t_tdata d;
      for (int i = 0; i < len; i++)
      begin
         d = (i == 0) ? first_beat(pick_opcode(), 1'b0, pcie_app_pkg::t_tag'($urandom))
                      : {$urandom, $urandom};
         rx_exp_data.push_back(d);
         rx_exp_last.push_back(i == len - 1);
         @(negedge fim_clk);
         rxreq_in_tvalid = 1'b1;
         rxreq_in_tdata  = d;
         rxreq_in_tlast  = (i == len - 1);
         @(posedge fim_clk);
         while (!rxreq_in_tready) @(posedge fim_clk);
      end
      @(negedge fim_clk);
      rxreq_in_tvalid = 1'b0;
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while ((tx_exp_data.size() + rx_exp_data.size() + cpl_exp.size()) != 0
             && cycles < DRAIN_CYCLES)
      begin
         @(posedge fim_clk);
         cycles++;
      end
      repeat (10) @(posedge fim_clk);     // Room for stray beats to show up
      if ((tx_exp_data.size() + rx_exp_data.size() + cpl_exp.size()) != 0)
      begin
         $display("Beats never arrived: %0d TX, %0d RXREQ, %0d commit still expected",
                  tx_exp_data.size(), rx_exp_data.size(), cpl_exp.size());
         other_errors++;
      end
   endtask

   // ------------------------------
   // Tests
   // ------------------------------
   task automatic reset_state();
      check_flag("rxreq_out_tvalid after reset", rxreq_out_tvalid, 1'b0);
      check_flag("tx_out_tvalid after reset", tx_out_tvalid, 1'b0);
      check_tag_mode("after reset", tag_mode, pcie_app_pkg::TAG_8BIT);
   endtask

   task automatic tx_passthrough();
      for (int i = 0; i < N_PASS; i++)
         send_tx_packet(pick_opcode(), 1'b0, 1 + $urandom % MAX_LEN);
      wait_drain();
   endtask

   task automatic write_commits();
      send_tx_packet(pcie_app_pkg::OP_MWR, 1'b1, 1);   // Single beat commit
      send_tx_packet(pcie_app_pkg::OP_MWR, 1'b1, 3);
      send_tx_packet(pcie_app_pkg::OP_MRD, 1'b1, 1);   // Flag on a read, no commit
      for (int i = 0; i < N_CMT - 3; i++)
         send_tx_packet(pick_opcode(), ($urandom % 2) == 0, 1 + $urandom % MAX_LEN);
      wait_drain();
   endtask

   task automatic rxreq_merge();
      fork
         for (int i = 0; i < N_MERGE; i++)
            send_rx_packet(1 + $urandom % MAX_LEN);
         for (int j = 0; j < N_MERGE; j++)
            send_tx_packet(pcie_app_pkg::OP_MWR, 1'b1, 1 + $urandom % 2);
      join
      wait_drain();
   endtask

   task automatic random_backpressure();
      rand_ready = 1'b1;
      fork
         for (int i = 0; i < N_BP; i++)
            send_rx_packet(1 + $urandom % MAX_LEN);
         for (int j = 0; j < N_BP; j++)
            send_tx_packet(pick_opcode(), ($urandom % 4) != 0, 1 + $urandom % 2);
      join
      wait_drain();
      rand_ready = 1'b0;
   endtask

   task automatic tag_mode_updates();
      logic [63:0]                           r;
      logic [pcie_app_pkg::CTRLSHADOW_W-1:0] w;
      pcie_app_pkg::t_tag_mode               exp;
      for (int k = 0; k < 4; k++)
      begin
         r = {$urandom, $urandom};
         w = r[pcie_app_pkg::CTRLSHADOW_W-1:0];
         w[pcie_app_pkg::SHADOW_TAG8_BIT]  = k[0];
         w[pcie_app_pkg::SHADOW_TAG10_BIT] = k[1];
         exp = k[1] ? pcie_app_pkg::TAG_10BIT :
               (k[0] ? pcie_app_pkg::TAG_8BIT : pcie_app_pkg::TAG_5BIT);
         @(negedge fim_clk);
         ctrlshadow_tvalid = 1'b1;
         ctrlshadow_tdata  = w;
         @(negedge fim_clk);
         ctrlshadow_tvalid = 1'b0;
         ctrlshadow_tdata  = ~w;           // Ignored without tvalid
         check_tag_mode("after update", tag_mode, exp);
         @(negedge fim_clk);
         check_tag_mode("between updates", tag_mode, exp);
      end
   endtask

   initial
   begin
      arst_n            = 1'b0;
      tx_in_tvalid      = 1'b0;
      tx_in_tlast       = 1'b0;
      tx_in_tdata       = '0;
      tx_out_tready     = 1'b1;
      rxreq_in_tvalid   = 1'b0;
      rxreq_in_tlast    = 1'b0;
      rxreq_in_tdata    = '0;
      rxreq_out_tready  = 1'b1;
      ctrlshadow_tvalid = 1'b0;
      ctrlshadow_tdata  = '0;
      void'($urandom(32'hf0c4));
      repeat (10) @(posedge fim_clk);
      @(negedge fim_clk);
      arst_n = 1'b1;

      reset_state();
      tx_passthrough();
      write_commits();
      rxreq_merge();
      random_backpressure();
      tag_mode_updates();

      $display("Errors: %0d beat, %0d tag mode, %0d flag, %0d other",
               beat_errors, mode_errors, flag_errors, other_errors);
      if (beat_errors + mode_errors + flag_errors + other_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule : tb_pcie_app_bridge

// ==== logic/pcie_app_bridge.sv ====
// ------------------------------
// Single link, everything on fim_clk
// ------------------------------

`timescale 1ns/10ps

module pcie_app_bridge #(
   parameter int RXREQ_DEPTH  = 4,
   parameter int COMMIT_DEPTH = 4
)(
   input  logic                                  fim_clk,
   input  logic                                  arst_n,

   // TX from the application toward the subsystem
   input  logic                                  tx_in_tvalid,
   output logic                                  tx_in_tready,
   input  logic                                  tx_in_tlast,
   input  pcie_app_pkg::t_tdata                  tx_in_tdata,
   output logic                                  tx_out_tvalid,
   input  logic                                  tx_out_tready,
   output logic                                  tx_out_tlast,
   output pcie_app_pkg::t_tdata                  tx_out_tdata,

   // RXREQ from the subsystem toward the application
   input  logic                                  rxreq_in_tvalid,
   output logic                                  rxreq_in_tready,
   input  logic                                  rxreq_in_tlast,
   input  pcie_app_pkg::t_tdata                  rxreq_in_tdata,
   output logic                                  rxreq_out_tvalid,
   input  logic                                  rxreq_out_tready,
   output logic                                  rxreq_out_tlast,
   output pcie_app_pkg::t_tdata                  rxreq_out_tdata,

   input  logic                                  ctrlshadow_tvalid,
   input  logic [pcie_app_pkg::CTRLSHADOW_W-1:0] ctrlshadow_tdata,
   output pcie_app_pkg::t_tag_mode               tag_mode
);

   logic                   req_valid;
   logic                   req_ready;
   pcie_app_pkg::t_rx_beat req_beat;

   logic                   commit_valid;
   logic                   commit_ready;
   pcie_app_pkg::t_tag     commit_tag;

   logic                   cpl_valid;
   logic                   cpl_ready;
   pcie_app_pkg::t_tag     cpl_tag;

   // ------------------------------
   // Buffering
   // ------------------------------
   stream_fifo #(
      .T     (pcie_app_pkg::t_rx_beat),
      .DEPTH (RXREQ_DEPTH)
   ) u_rxreq_fifo (
      .fim_clk   (fim_clk),
      .arst_n    (arst_n),
      .in_valid  (rxreq_in_tvalid),
      .in_ready  (rxreq_in_tready),
      .in_data   ({rxreq_in_tlast, rxreq_in_tdata}),
      .out_valid (req_valid),
      .out_ready (req_ready),
      .out_data  (req_beat)
   );

   stream_fifo #(
      .T     (pcie_app_pkg::t_tag),
      .DEPTH (COMMIT_DEPTH)
   ) u_commit_fifo (
      .fim_clk   (fim_clk),
      .arst_n    (arst_n),
      .in_valid  (commit_valid),
      .in_ready  (commit_ready),
      .in_data   (commit_tag),
      .out_valid (cpl_valid),
      .out_ready (cpl_ready),
      .out_data  (cpl_tag)
   );

   // ------------------------------
   // TX commits and RXREQ merge
   // ------------------------------
   write_commit_gen u_write_commit_gen (
      .fim_clk       (fim_clk),
      .arst_n        (arst_n),
      .tx_in_tvalid  (tx_in_tvalid),
      .tx_in_tready  (tx_in_tready),
      .tx_in_tlast   (tx_in_tlast),
      .tx_in_tdata   (tx_in_tdata),
      .tx_out_tvalid (tx_out_tvalid),
      .tx_out_tready (tx_out_tready),
      .tx_out_tlast  (tx_out_tlast),
      .tx_out_tdata  (tx_out_tdata),
      .commit_valid  (commit_valid),
      .commit_ready  (commit_ready),
      .commit_tag    (commit_tag)
   );

   rxreq_arbiter u_rxreq_arbiter (
      .fim_clk          (fim_clk),
      .arst_n           (arst_n),
      .req_valid        (req_valid),
      .req_ready        (req_ready),
      .req_beat         (req_beat),
      .cpl_valid        (cpl_valid),
      .cpl_ready        (cpl_ready),
      .cpl_tag          (cpl_tag),
      .rxreq_out_tvalid (rxreq_out_tvalid),
      .rxreq_out_tready (rxreq_out_tready),
      .rxreq_out_tlast  (rxreq_out_tlast),
      .rxreq_out_tdata  (rxreq_out_tdata)
   );

   tag_mode_shadow u_tag_mode_shadow (
      .fim_clk           (fim_clk),
      .arst_n            (arst_n),
      .ctrlshadow_tvalid (ctrlshadow_tvalid),
      .ctrlshadow_tdata  (ctrlshadow_tdata),
      .tag_mode          (tag_mode)
   );

endmodule : pcie_app_bridge

// ==== logic/tag_mode_shadow.sv ====
// ------------------------------
// New mode takes effect one cycle after the shadow beat
// ------------------------------

`timescale 1ns/10ps

module tag_mode_shadow (
   input  logic                                 fim_clk,
   input  logic                                 arst_n,
   input  logic                                 ctrlshadow_tvalid,
   input  logic [pcie_app_pkg::CTRLSHADOW_W-1:0] ctrlshadow_tdata,
   output pcie_app_pkg::t_tag_mode              tag_mode
);

   pcie_app_pkg::t_tag_mode mode_next;

   // 10-bit enable outranks extended tags
   always_comb
   begin
      if (ctrlshadow_tdata[pcie_app_pkg::SHADOW_TAG10_BIT])
         mode_next = pcie_app_pkg::TAG_10BIT;
      else if (ctrlshadow_tdata[pcie_app_pkg::SHADOW_TAG8_BIT])
         mode_next = pcie_app_pkg::TAG_8BIT;
      else
         mode_next = pcie_app_pkg::TAG_5BIT;
   end

   always_ff @(posedge fim_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tag_mode <= pcie_app_pkg::TAG_8BIT;  // Default until first shadow update
      end
      else if (ctrlshadow_tvalid)
      begin
         tag_mode <= mode_next;
      end
   end

   assert property (@(posedge fim_clk) disable iff (!arst_n)
      tag_mode inside {pcie_app_pkg::TAG_5BIT, pcie_app_pkg::TAG_8BIT,
                       pcie_app_pkg::TAG_10BIT});

endmodule : tag_mode_shadow

// ==== logic/rxreq_arbiter.sv ====
// ------------------------------
// Grant is registered, one idle cycle between packets
// Source 0 is RXREQ, source 1 is commit completions
// ------------------------------

`timescale 1ns/10ps

module rxreq_arbiter (
   input  logic                   fim_clk,
   input  logic                   arst_n,

   input  logic                   req_valid,
   output logic                   req_ready,
   input  pcie_app_pkg::t_rx_beat req_beat,

   input  logic                   cpl_valid,
   output logic                   cpl_ready,
   input  pcie_app_pkg::t_tag     cpl_tag,

   output logic                   rxreq_out_tvalid,
   input  logic                   rxreq_out_tready,
   output logic                   rxreq_out_tlast,
   output pcie_app_pkg::t_tdata   rxreq_out_tdata
);

   logic                 active;      // Packet lock held
   logic                 grant;       // Locked source
   logic                 rr_next;     // Preferred source when idle
   logic                 out_fire;
   pcie_app_pkg::t_tdata cpl_data;

   // Completion without data, only opcode and tag set
   always_comb
   begin
      cpl_data = '0;
      cpl_data[pcie_app_pkg::OPCODE_LSB +: pcie_app_pkg::OPCODE_W] = pcie_app_pkg::OP_CPL_NODATA;
      cpl_data[pcie_app_pkg::TAG_LSB +: pcie_app_pkg::TAG_W]       = cpl_tag;
   end

   assign rxreq_out_tvalid = active && (grant ? cpl_valid : req_valid);
   assign rxreq_out_tlast  = grant ? 1'b1 : req_beat.tlast;
   assign rxreq_out_tdata  = grant ? cpl_data : req_beat.tdata;

   assign req_ready = active && !grant && rxreq_out_tready;
   assign cpl_ready = active && grant && rxreq_out_tready;
   assign out_fire  = rxreq_out_tvalid && rxreq_out_tready;

   always_ff @(posedge fim_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         active  <= 1'b0;
         grant   <= 1'b0;
         rr_next <= 1'b0;
      end
      else if (!active)
      begin
         if (req_valid || cpl_valid)
         begin
            active <= 1'b1;
            // Preferred source wins, otherwise whoever is asking
            grant  <= rr_next ? cpl_valid : !req_valid;
         end
      end
      else if (out_fire && rxreq_out_tlast)
      begin
         active  <= 1'b0;
         rr_next <= !grant;                  // Round robin past the one served
      end
   end

   // Only RXREQ packets span beats, so a packet in progress keeps source 0
   assert property (@(posedge fim_clk) disable iff (!arst_n)
      out_fire && !rxreq_out_tlast |=> active && !grant);

endmodule : rxreq_arbiter

// ==== logic/write_commit_gen.sv ====
// ------------------------------
// TX path is combinational, zero latency
// Last beat of a committed write waits for room in the commit queue
// ------------------------------

`timescale 1ns/10ps

module write_commit_gen (
   input  logic                  fim_clk,
   input  logic                  arst_n,

   input  logic                  tx_in_tvalid,
   output logic                  tx_in_tready,
   input  logic                  tx_in_tlast,
   input  pcie_app_pkg::t_tdata  tx_in_tdata,

   output logic                  tx_out_tvalid,
   input  logic                  tx_out_tready,
   output logic                  tx_out_tlast,
   output pcie_app_pkg::t_tdata  tx_out_tdata,

   output logic                  commit_valid,
   input  logic                  commit_ready,
   output pcie_app_pkg::t_tag    commit_tag
);

   logic               first_beat;      // Next beat opens a packet
   logic               commit_q;        // Packet in flight is a committed write
   pcie_app_pkg::t_tag tag_q;
   logic               hdr_commit;
   logic               commit_now;
   logic               stall;
   logic               in_fire;

   // Header decode, only meaningful on a first beat
   assign hdr_commit =
      (tx_in_tdata[pcie_app_pkg::OPCODE_LSB +: pcie_app_pkg::OPCODE_W] == pcie_app_pkg::OP_MWR)
      && tx_in_tdata[pcie_app_pkg::COMMIT_REQ_BIT];

   // Single-beat packets are decoded straight from the bus
   assign commit_now = first_beat ? hdr_commit : commit_q;
   assign commit_tag = first_beat ? tx_in_tdata[pcie_app_pkg::TAG_LSB +: pcie_app_pkg::TAG_W]
                                  : tag_q;

   assign stall = tx_in_tvalid && tx_in_tlast && commit_now && !commit_ready;

   // ------------------------------
   // Pass-through
   // ------------------------------
   assign tx_out_tvalid = tx_in_tvalid && !stall;   // Hidden from the subsystem while stalled
   assign tx_out_tlast  = tx_in_tlast;
   assign tx_out_tdata  = tx_in_tdata;
   assign tx_in_tready  = tx_out_tready && !stall;

   assign in_fire      = tx_in_tvalid && tx_in_tready;
   assign commit_valid = tx_in_tvalid && tx_in_tlast && commit_now && tx_out_tready;

   always_ff @(posedge fim_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         first_beat <= 1'b1;
         commit_q   <= 1'b0;
         tag_q      <= '0;
      end
      else if (in_fire)
      begin
         first_beat <= tx_in_tlast;
         if (first_beat)
         begin
            commit_q <= hdr_commit;
            tag_q    <= tx_in_tdata[pcie_app_pkg::TAG_LSB +: pcie_app_pkg::TAG_W];
         end
      end
   end

   // Subsystem sees a held beat while it back-pressures
   assert property (@(posedge fim_clk) disable iff (!arst_n)
      tx_out_tvalid && !tx_out_tready |=> $stable(tx_out_tdata));

endmodule : write_commit_gen

// ==== logic/stream_fifo.sv ====
// ------------------------------
// Output is read from the array, one cycle after the push
// ------------------------------

`timescale 1ns/10ps

module stream_fifo #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = 4
)(
   input  logic fim_clk,
   input  logic arst_n,

   input  logic in_valid,
   output logic in_ready,
   input  T     in_data,

   output logic out_valid,
   input  logic out_ready,
   output T     out_data
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T                 mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;       // Occupancy
   logic             push;
   logic             pop;

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   always_ff @(posedge fim_clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= in_data;
      end
   end

   always_ff @(posedge fim_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Occupancy stays in range, so no push when full and no pop when empty
   assert property (@(posedge fim_clk) disable iff (!arst_n)
      count <= CNT_W'(DEPTH));

   // Empty and full both leave the pointers level
   assert property (@(posedge fim_clk) disable iff (!arst_n)
      (count == '0) || (count == CNT_W'(DEPTH)) |-> (wr_ptr == rd_ptr));

endmodule : stream_fifo

// ==== logic/pcie_app_pkg.sv ====
// ------------------------------
// Header fields sit in the first beat of a packet only
// Opcode values are bridge-local, not full PCIe fmt/type
// ------------------------------

package pcie_app_pkg;

   // ------------------------------
   // Stream beat
   // ------------------------------
   localparam int TDATA_W = 64;

   typedef logic [TDATA_W-1:0] t_tdata;

   // ------------------------------
   // First-beat header fields
   // ------------------------------
   localparam int OPCODE_LSB     = 0;
   localparam int OPCODE_W       = 8;
   localparam int COMMIT_REQ_BIT = 8;    // Write asks for a commit completion
   localparam int TAG_LSB        = 16;
   localparam int TAG_W          = 10;

   typedef enum logic [OPCODE_W-1:0] {
      OP_MRD        = 8'h00,
      OP_CPL_NODATA = 8'h0a,
      OP_MSG        = 8'h30,
      OP_MWR        = 8'h40
   } t_opcode;

   typedef logic [TAG_W-1:0] t_tag;

   // RXREQ FIFO entry, tlast in the top bit
   typedef struct packed {
      logic   tlast;
      t_tdata tdata;
   } t_rx_beat;

   // ------------------------------
   // Control shadow
   // ------------------------------
   localparam int CTRLSHADOW_W     = 40;
   localparam int SHADOW_TAG8_BIT  = 8;  // Extended tag enable
   localparam int SHADOW_TAG10_BIT = 9;  // 10-bit tag requester enable

   typedef enum logic [1:0] {
      TAG_5BIT  = 2'd0,
      TAG_8BIT  = 2'd1,
      TAG_10BIT = 2'd2
   } t_tag_mode;

endpackage : pcie_app_pkg
